// ==== all.f ====
cpu_cfg_pkg.sv
issue_pkg.sv
scoreboard.sv
pair_hazard_check.sv
issue_ctrl.sv
icu.sv
issue_stage_top.sv
tb_issue_stage.sv

// ==== cpu_cfg_pkg.sv ====
// core-wide widths shared by every block of the dispatch slice
// modules pull these in with a wildcard import in their header
package cpu_cfg_pkg;

    // instruction address, one per lane
    localparam int INST_ADDR_WIDTH = 32;

    // decoded immediate as handed over by the decoder
    localparam int IMM_WIDTH = 32;

    // architectural register address
    // 5 for RV32I, the top level may pass 4 for RV32E
    localparam int DEFAULT_REG_ADDR_W = 5;

    // instructions presented and issued per cycle, lane 1 is the older
    localparam int ISSUE_WIDTH = 2;

endpackage

// ==== icu.sv ====
// issue register, latches each granted lane's decoded fields for execute
// flush zeroes everything, stall holds everything including valid
`timescale 1ns/1ps

module icu
    import cpu_cfg_pkg::*;
    import issue_pkg::*;
#(
    parameter int REG_ADDR_W = DEFAULT_REG_ADDR_W
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [ISSUE_WIDTH-1:0]      issue_grant_i,
    input  logic                        flush_i,
    input  logic                        stall_dispatch_i,

    // lane 1 from the decoder
    input  logic [INST_ADDR_WIDTH-1:0]  inst1_addr_i,
    input  logic                        inst1_reg_we_i,
    input  logic [REG_ADDR_W-1:0]       inst1_rd_i,
    input  logic [REG_ADDR_W-1:0]       inst1_rs1_i,
    input  logic [REG_ADDR_W-1:0]       inst1_rs2_i,
    input  logic [IMM_WIDTH-1:0]        inst1_imm_i,
    input  logic [DECINFO_WIDTH-1:0]    inst1_dec_info_i,
    input  logic                        inst1_pred_branch_i,

    // lane 2 from the decoder
    input  logic [INST_ADDR_WIDTH-1:0]  inst2_addr_i,
    input  logic                        inst2_reg_we_i,
    input  logic [REG_ADDR_W-1:0]       inst2_rd_i,
    input  logic [REG_ADDR_W-1:0]       inst2_rs1_i,
    input  logic [REG_ADDR_W-1:0]       inst2_rs2_i,
    input  logic [IMM_WIDTH-1:0]        inst2_imm_i,
    input  logic [DECINFO_WIDTH-1:0]    inst2_dec_info_i,
    input  logic                        inst2_pred_branch_i,

    // lane 1 to execute
    output logic                        lane1_valid_o,
    output logic [INST_ADDR_WIDTH-1:0]  inst1_addr_o,
    output logic                        inst1_reg_we_o,
    output logic [REG_ADDR_W-1:0]       inst1_rd_o,
    output logic [REG_ADDR_W-1:0]       inst1_rs1_o,
    output logic [REG_ADDR_W-1:0]       inst1_rs2_o,
    output logic [IMM_WIDTH-1:0]        inst1_imm_o,
    output logic [DECINFO_WIDTH-1:0]    inst1_dec_info_o,
    output logic                        inst1_pred_branch_o,

    // lane 2 to execute
    output logic                        lane2_valid_o,
    output logic [INST_ADDR_WIDTH-1:0]  inst2_addr_o,
    output logic                        inst2_reg_we_o,
    output logic [REG_ADDR_W-1:0]       inst2_rd_o,
    output logic [REG_ADDR_W-1:0]       inst2_rs1_o,
    output logic [REG_ADDR_W-1:0]       inst2_rs2_o,
    output logic [IMM_WIDTH-1:0]        inst2_imm_o,
    output logic [DECINFO_WIDTH-1:0]    inst2_dec_info_o,
    output logic                        inst2_pred_branch_o
);

    // lane 1 register
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            lane1_valid_o       <= 1'b0;
            inst1_addr_o        <= '0;
            inst1_reg_we_o      <= 1'b0;
            inst1_rd_o          <= '0;
            inst1_rs1_o         <= '0;
            inst1_rs2_o         <= '0;
            inst1_imm_o         <= '0;
            inst1_dec_info_o    <= '0;
            inst1_pred_branch_o <= 1'b0;
        end else if (!stall_dispatch_i) begin
            // ungranted lane drops valid but keeps the old fields
            lane1_valid_o <= issue_grant_i[0];
            if (issue_grant_i[0]) begin
                inst1_addr_o        <= inst1_addr_i;
                inst1_reg_we_o      <= inst1_reg_we_i;
                inst1_rd_o          <= inst1_rd_i;
                inst1_rs1_o         <= inst1_rs1_i;
                inst1_rs2_o         <= inst1_rs2_i;
                inst1_imm_o         <= inst1_imm_i;
                inst1_dec_info_o    <= inst1_dec_info_i;
                inst1_pred_branch_o <= inst1_pred_branch_i;
            end
        end
    end

    // lane 2 register, same rules on its own grant bit
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            lane2_valid_o       <= 1'b0;
            inst2_addr_o        <= '0;
            inst2_reg_we_o      <= 1'b0;
            inst2_rd_o          <= '0;
            inst2_rs1_o         <= '0;
            inst2_rs2_o         <= '0;
            inst2_imm_o         <= '0;
            inst2_dec_info_o    <= '0;
            inst2_pred_branch_o <= 1'b0;
        end else if (!stall_dispatch_i) begin
            lane2_valid_o <= issue_grant_i[1];
            if (issue_grant_i[1]) begin
                inst2_addr_o        <= inst2_addr_i;
                inst2_reg_we_o      <= inst2_reg_we_i;
                inst2_rd_o          <= inst2_rd_i;
                inst2_rs1_o         <= inst2_rs1_i;
                inst2_rs2_o         <= inst2_rs2_i;
                inst2_imm_o         <= inst2_imm_i;
                inst2_dec_info_o    <= inst2_dec_info_i;
                inst2_pred_branch_o <= inst2_pred_branch_i;
            end
        end
    end

    // execute never sees the younger lane alone
    a_lane2_with_lane1: assert property (
        @(posedge clk) disable iff (reset_i)
        lane2_valid_o |-> lane1_valid_o
    ) else $error("icu: lane 2 valid without lane 1");

endmodule

// ==== issue_ctrl.sv ====
// turns hazard results plus stall and flush into the per-lane issue grants
// grants are in order, lane 2 can only go together with lane 1
`timescale 1ns/1ps

module issue_ctrl
    import cpu_cfg_pkg::*;
(
    input  logic                   inst1_valid_i,
    input  logic                   inst2_valid_i,

    // from scoreboard and pair checker
    input  logic                   lane1_busy_i,
    input  logic                   lane2_busy_i,
    input  logic                   pair_conflict_i,

    // from control
    input  logic                   stall_dispatch_i,
    input  logic                   flush_i,

    output logic [ISSUE_WIDTH-1:0] issue_grant_o
);

    logic lane1_ready;
    logic lane2_ready;

    always_comb begin
        lane1_ready = inst1_valid_i && !lane1_busy_i;
        // lane 2 also needs a clean pair
        lane2_ready = inst2_valid_i && !lane2_busy_i && !pair_conflict_i;

        issue_grant_o = '0;
        if (!stall_dispatch_i && !flush_i) begin
            issue_grant_o[0] = lane1_ready;
            issue_grant_o[1] = lane1_ready && lane2_ready;
        end
    end

endmodule

// ==== issue_pkg.sv ====
// layout of the decode-info bus that travels with each decoded instruction
// the issue logic only looks at the execution unit group field
package issue_pkg;

    localparam int DECINFO_WIDTH = 16;

    // unit group sits in the low bits, unit specific opcode bits above it
    localparam int DEC_GRP_LSB = 0;
    localparam int DEC_GRP_W   = 3;

    // execution unit an instruction needs
    localparam logic [DEC_GRP_W-1:0] GRP_ALU = 3'd1;
    localparam logic [DEC_GRP_W-1:0] GRP_BJP = 3'd2;
    localparam logic [DEC_GRP_W-1:0] GRP_MEM = 3'd3;
    localparam logic [DEC_GRP_W-1:0] GRP_MUL = 3'd4;

    // pull the unit group out of a decode-info word
    function automatic logic [DEC_GRP_W-1:0] dec_grp(input logic [DECINFO_WIDTH-1:0] info);
        return info[DEC_GRP_LSB +: DEC_GRP_W];
    endfunction

endpackage

// ==== issue_stage_top.sv ====
// dispatch slice of the dual-issue core: hazard checks, issue decision, issue register
// issue_o back to the decoder is combinational, execute outputs follow one clock later
`timescale 1ns/1ps

module issue_stage_top
    import cpu_cfg_pkg::*;
    import issue_pkg::*;
#(
    parameter int REG_ADDR_W = DEFAULT_REG_ADDR_W
) (
    input  logic                        clk,
    input  logic                        reset_i,

    // decoder, lane 1
    input  logic                        inst1_valid_i,
    input  logic [INST_ADDR_WIDTH-1:0]  inst1_addr_i,
    input  logic                        inst1_reg_we_i,
    input  logic [REG_ADDR_W-1:0]       inst1_rd_i,
    input  logic [REG_ADDR_W-1:0]       inst1_rs1_i,
    input  logic [REG_ADDR_W-1:0]       inst1_rs2_i,
    input  logic [IMM_WIDTH-1:0]        inst1_imm_i,
    input  logic [DECINFO_WIDTH-1:0]    inst1_dec_info_i,
    input  logic                        inst1_pred_branch_i,

    // decoder, lane 2
    input  logic                        inst2_valid_i,
    input  logic [INST_ADDR_WIDTH-1:0]  inst2_addr_i,
    input  logic                        inst2_reg_we_i,
    input  logic [REG_ADDR_W-1:0]       inst2_rd_i,
    input  logic [REG_ADDR_W-1:0]       inst2_rs1_i,
    input  logic [REG_ADDR_W-1:0]       inst2_rs2_i,
    input  logic [IMM_WIDTH-1:0]        inst2_imm_i,
    input  logic [DECINFO_WIDTH-1:0]    inst2_dec_info_i,
    input  logic                        inst2_pred_branch_i,

    // control and writeback
    input  logic                        flush_i,
    input  logic                        stall_dispatch_i,
    input  logic                        wb_we_i,
    input  logic [REG_ADDR_W-1:0]       wb_rd_i,

    // handshake back to the decoder
    output logic [ISSUE_WIDTH-1:0]      issue_o,

    // execute side
    output logic                        lane1_valid_o,
    output logic [INST_ADDR_WIDTH-1:0]  inst1_addr_o,
    output logic                        inst1_reg_we_o,
    output logic [REG_ADDR_W-1:0]       inst1_rd_o,
    output logic [REG_ADDR_W-1:0]       inst1_rs1_o,
    output logic [REG_ADDR_W-1:0]       inst1_rs2_o,
    output logic [IMM_WIDTH-1:0]        inst1_imm_o,
    output logic [DECINFO_WIDTH-1:0]    inst1_dec_info_o,
    output logic                        inst1_pred_branch_o,
    output logic                        lane2_valid_o,
    output logic [INST_ADDR_WIDTH-1:0]  inst2_addr_o,
    output logic                        inst2_reg_we_o,
    output logic [REG_ADDR_W-1:0]       inst2_rd_o,
    output logic [REG_ADDR_W-1:0]       inst2_rs1_o,
    output logic [REG_ADDR_W-1:0]       inst2_rs2_o,
    output logic [IMM_WIDTH-1:0]        inst2_imm_o,
    output logic [DECINFO_WIDTH-1:0]    inst2_dec_info_o,
    output logic                        inst2_pred_branch_o
);

    logic                   lane1_busy;
    logic                   lane2_busy;
    logic                   pair_conflict;
    logic [ISSUE_WIDTH-1:0] issue_grant;

    assign issue_o = issue_grant;

    scoreboard #(.REG_ADDR_W(REG_ADDR_W)) u_scoreboard (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i), .issue_grant_i(issue_grant),
        .inst1_reg_we_i(inst1_reg_we_i), .inst1_rd_i(inst1_rd_i),
        .inst1_rs1_i(inst1_rs1_i), .inst1_rs2_i(inst1_rs2_i),
        .inst2_reg_we_i(inst2_reg_we_i), .inst2_rd_i(inst2_rd_i),
        .inst2_rs1_i(inst2_rs1_i), .inst2_rs2_i(inst2_rs2_i),
        .wb_we_i(wb_we_i), .wb_rd_i(wb_rd_i),
        .lane1_busy_o(lane1_busy), .lane2_busy_o(lane2_busy)
    );

    pair_hazard_check #(.REG_ADDR_W(REG_ADDR_W)) u_pair_hazard_check (
        .inst1_reg_we_i(inst1_reg_we_i), .inst1_rd_i(inst1_rd_i),
        .inst1_dec_info_i(inst1_dec_info_i),
        .inst2_rs1_i(inst2_rs1_i), .inst2_rs2_i(inst2_rs2_i), .inst2_rd_i(inst2_rd_i),
        .inst2_dec_info_i(inst2_dec_info_i),
        .pair_conflict_o(pair_conflict)
    );

    issue_ctrl u_issue_ctrl (
        .inst1_valid_i(inst1_valid_i), .inst2_valid_i(inst2_valid_i),
        .lane1_busy_i(lane1_busy), .lane2_busy_i(lane2_busy),
        .pair_conflict_i(pair_conflict),
        .stall_dispatch_i(stall_dispatch_i), .flush_i(flush_i),
        .issue_grant_o(issue_grant)
    );

    icu #(.REG_ADDR_W(REG_ADDR_W)) u_icu (
        .clk(clk), .reset_i(reset_i), .issue_grant_i(issue_grant),
        .flush_i(flush_i), .stall_dispatch_i(stall_dispatch_i),
        .inst1_addr_i(inst1_addr_i), .inst1_reg_we_i(inst1_reg_we_i),
        .inst1_rd_i(inst1_rd_i), .inst1_rs1_i(inst1_rs1_i), .inst1_rs2_i(inst1_rs2_i),
        .inst1_imm_i(inst1_imm_i), .inst1_dec_info_i(inst1_dec_info_i),
        .inst1_pred_branch_i(inst1_pred_branch_i),
        .inst2_addr_i(inst2_addr_i), .inst2_reg_we_i(inst2_reg_we_i),
        .inst2_rd_i(inst2_rd_i), .inst2_rs1_i(inst2_rs1_i), .inst2_rs2_i(inst2_rs2_i),
        .inst2_imm_i(inst2_imm_i), .inst2_dec_info_i(inst2_dec_info_i),
        .inst2_pred_branch_i(inst2_pred_branch_i),
        .lane1_valid_o(lane1_valid_o), .inst1_addr_o(inst1_addr_o),
        .inst1_reg_we_o(inst1_reg_we_o), .inst1_rd_o(inst1_rd_o),
        .inst1_rs1_o(inst1_rs1_o), .inst1_rs2_o(inst1_rs2_o), .inst1_imm_o(inst1_imm_o),
        .inst1_dec_info_o(inst1_dec_info_o), .inst1_pred_branch_o(inst1_pred_branch_o),
        .lane2_valid_o(lane2_valid_o), .inst2_addr_o(inst2_addr_o),
        .inst2_reg_we_o(inst2_reg_we_o), .inst2_rd_o(inst2_rd_o),
        .inst2_rs1_o(inst2_rs1_o), .inst2_rs2_o(inst2_rs2_o), .inst2_imm_o(inst2_imm_o),
        .inst2_dec_info_o(inst2_dec_info_o), .inst2_pred_branch_o(inst2_pred_branch_o)
    );

endmodule

// ==== pair_hazard_check.sv ====
// conflicts inside one decoded pair, lane 2 against the older lane 1
// purely combinational, result feeds issue_ctrl in the same cycle
`timescale 1ns/1ps

module pair_hazard_check
    import cpu_cfg_pkg::*;
    import issue_pkg::*;
#(
    parameter int REG_ADDR_W = DEFAULT_REG_ADDR_W
) (
    // lane 1 destination
    input  logic                     inst1_reg_we_i,
    input  logic [REG_ADDR_W-1:0]    inst1_rd_i,
    input  logic [DECINFO_WIDTH-1:0] inst1_dec_info_i,

    // lane 2 sources and destination
    input  logic [REG_ADDR_W-1:0]    inst2_rs1_i,
    input  logic [REG_ADDR_W-1:0]    inst2_rs2_i,
    input  logic [REG_ADDR_W-1:0]    inst2_rd_i,
    input  logic [DECINFO_WIDTH-1:0] inst2_dec_info_i,

    output logic                     pair_conflict_o
);

    logic                 inst1_writes;
    logic                 raw_hazard;
    logic                 waw_hazard;
    logic [DEC_GRP_W-1:0] inst1_grp;
    logic [DEC_GRP_W-1:0] inst2_grp;
    logic                 unit_clash;

    // a write to x0 is dropped, so it never orders the pair
    assign inst1_writes = inst1_reg_we_i && inst1_rd_i != '0;

    // lane 2 reads what lane 1 is about to write
    assign raw_hazard = inst1_writes
                     && (inst1_rd_i == inst2_rs1_i || inst1_rd_i == inst2_rs2_i);

    // both lanes name the same destination
    assign waw_hazard = inst1_writes && inst1_rd_i == inst2_rd_i;

    assign inst1_grp = dec_grp(inst1_dec_info_i);
    assign inst2_grp = dec_grp(inst2_dec_info_i);

    // only one load/store unit and one multiplier
    assign unit_clash = (inst1_grp == GRP_MEM && inst2_grp == GRP_MEM)
                     || (inst1_grp == GRP_MUL && inst2_grp == GRP_MUL);

    assign pair_conflict_o = raw_hazard || waw_hazard || unit_clash;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the issue stage testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_issue_stage -f all.f -o sim_issue \
    && ./obj_dir/sim_issue > sim.log 2>&1
[ -f sim.log ] || { echo "simulation did not run"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

// ==== scoreboard.sv ====
// pending-write scoreboard, one bit per architectural register
// issue sets a bit, writeback clears it, flush empties the whole table
`timescale 1ns/1ps

module scoreboard
    import cpu_cfg_pkg::*;
#(
    parameter int REG_ADDR_W = DEFAULT_REG_ADDR_W
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  logic [ISSUE_WIDTH-1:0] issue_grant_i,

    // lane 1 register usage
    input  logic                   inst1_reg_we_i,
    input  logic [REG_ADDR_W-1:0]  inst1_rd_i,
    input  logic [REG_ADDR_W-1:0]  inst1_rs1_i,
    input  logic [REG_ADDR_W-1:0]  inst1_rs2_i,

    // lane 2 register usage
    input  logic                   inst2_reg_we_i,
    input  logic [REG_ADDR_W-1:0]  inst2_rd_i,
    input  logic [REG_ADDR_W-1:0]  inst2_rs1_i,
    input  logic [REG_ADDR_W-1:0]  inst2_rs2_i,

    // writeback port
    input  logic                   wb_we_i,
    input  logic [REG_ADDR_W-1:0]  wb_rd_i,

    output logic                   lane1_busy_o,
    output logic                   lane2_busy_o
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [NUM_REGS-1:0] pending_q;
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] clr_mask;
    logic [NUM_REGS-1:0] pending_d;

    // one-hot select of a register, x0 never selected
    function automatic logic [NUM_REGS-1:0] reg_mask(
        input logic                  en,
        input logic [REG_ADDR_W-1:0] addr
    );
        logic [NUM_REGS-1:0] mask;
        mask = '0;
        if (en && addr != '0) begin
            mask[addr] = 1'b1;
        end
        return mask;
    endfunction

    assign set_mask = reg_mask(issue_grant_i[0] && inst1_reg_we_i, inst1_rd_i)
                    | reg_mask(issue_grant_i[1] && inst2_reg_we_i, inst2_rd_i);
    assign clr_mask = reg_mask(wb_we_i, wb_rd_i);

    // set after clear so a same-cycle issue keeps the register pending
    assign pending_d = (pending_q & ~clr_mask) | set_mask;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

    // lane busy if any named register, other than x0, waits on a write
    always_comb begin
        lane1_busy_o = (inst1_rs1_i != '0 && pending_q[inst1_rs1_i])
                    || (inst1_rs2_i != '0 && pending_q[inst1_rs2_i])
                    || (inst1_rd_i  != '0 && pending_q[inst1_rd_i]);
        lane2_busy_o = (inst2_rs1_i != '0 && pending_q[inst2_rs1_i])
                    || (inst2_rs2_i != '0 && pending_q[inst2_rs2_i])
                    || (inst2_rd_i  != '0 && pending_q[inst2_rd_i]);
    end

    // grants come from issue_ctrl, they must respect the busy view here
    a_grant_not_busy: assert property (
        @(posedge clk) disable iff (reset_i)
        (!issue_grant_i[0] || !lane1_busy_o) && (!issue_grant_i[1] || !lane2_busy_o)
    ) else $error("scoreboard: busy lane was granted");

endmodule

// ==== tb_issue_stage.sv ====
// table-driven testbench for issue_stage_top, rows applied on the falling edge
// a pending-bit and issue-register model in here gives the expected values
`timescale 1ns/1ps

module tb_issue_stage
    import cpu_cfg_pkg::*;
    import issue_pkg::*;
;
    typedef struct packed {
        logic       v;
        logic       we;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] grp;
    } lane_t;

    typedef struct packed {
        lane_t      l1;
        lane_t      l2;
        logic       wb_we;
        logic [4:0] wb_rd;
        logic       stall;
        logic       flush;
        logic [1:0] exp_issue;
    } row_t;

    logic clk;
    logic reset_i;
    logic flush_i;
    logic stall_dispatch_i;
    logic wb_we_i;
    logic [4:0] wb_rd_i;

    // current decoder inputs, index 0 is lane 1
    logic        c_v[2];
    logic        c_we[2];
    logic [4:0]  c_rd[2];
    logic [4:0]  c_rs1[2];
    logic [4:0]  c_rs2[2];
    logic [31:0] c_addr[2];
    logic [31:0] c_imm[2];
    logic [15:0] c_info[2];
    logic        c_pb[2];

    // expected issue register contents
    logic        e_v[2];
    logic        e_we[2];
    logic [4:0]  e_rd[2];
    logic [4:0]  e_rs1[2];
    logic [4:0]  e_rs2[2];
    logic [31:0] e_addr[2];
    logic [31:0] e_imm[2];
    logic [15:0] e_info[2];
    logic        e_pb[2];

    logic [1:0]  issue_o;
    logic        o_v[2];
    logic        o_we[2];
    logic [4:0]  o_rd[2];
    logic [4:0]  o_rs1[2];
    logic [4:0]  o_rs2[2];
    logic [31:0] o_addr[2];
    logic [31:0] o_imm[2];
    logic [15:0] o_info[2];
    logic        o_pb[2];

    logic [31:0] pend;
    logic [15:0] lfsr_q;
    logic [1:0]  grant;
    row_t        rows[$];
    string       names[$];
    int          errors;
    int          checks;

    issue_stage_top uut (
        .clk(clk), .reset_i(reset_i),
        .inst1_valid_i(c_v[0]), .inst1_addr_i(c_addr[0]), .inst1_reg_we_i(c_we[0]),
        .inst1_rd_i(c_rd[0]), .inst1_rs1_i(c_rs1[0]), .inst1_rs2_i(c_rs2[0]),
        .inst1_imm_i(c_imm[0]), .inst1_dec_info_i(c_info[0]), .inst1_pred_branch_i(c_pb[0]),
        .inst2_valid_i(c_v[1]), .inst2_addr_i(c_addr[1]), .inst2_reg_we_i(c_we[1]),
        .inst2_rd_i(c_rd[1]), .inst2_rs1_i(c_rs1[1]), .inst2_rs2_i(c_rs2[1]),
        .inst2_imm_i(c_imm[1]), .inst2_dec_info_i(c_info[1]), .inst2_pred_branch_i(c_pb[1]),
        .flush_i(flush_i), .stall_dispatch_i(stall_dispatch_i),
        .wb_we_i(wb_we_i), .wb_rd_i(wb_rd_i),
        .issue_o(issue_o),
        .lane1_valid_o(o_v[0]), .inst1_addr_o(o_addr[0]), .inst1_reg_we_o(o_we[0]),
        .inst1_rd_o(o_rd[0]), .inst1_rs1_o(o_rs1[0]), .inst1_rs2_o(o_rs2[0]),
        .inst1_imm_o(o_imm[0]), .inst1_dec_info_o(o_info[0]), .inst1_pred_branch_o(o_pb[0]),
        .lane2_valid_o(o_v[1]), .inst2_addr_o(o_addr[1]), .inst2_reg_we_o(o_we[1]),
        .inst2_rd_o(o_rd[1]), .inst2_rs1_o(o_rs1[1]), .inst2_rs2_o(o_rs2[1]),
        .inst2_imm_o(o_imm[1]), .inst2_dec_info_o(o_info[1]), .inst2_pred_branch_o(o_pb[1])
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], b};
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic lane_t mk_lane(input int v, input int we, input int rd,
                                      input int rs1, input int rs2, input logic [2:0] grp);
        lane_t l;
        l.v = 1'(v);
        l.we = 1'(we);
        l.rd = 5'(rd);
        l.rs1 = 5'(rs1);
        l.rs2 = 5'(rs2);
        l.grp = grp;
        return l;
    endfunction

    task automatic add_row(input string name, input lane_t a, input lane_t b, input int wbwe,
                           input int wbrd, input int st, input int fl, input int exp_issue);
        row_t r;
        r.l1 = a;
        r.l2 = b;
        r.wb_we = 1'(wbwe);
        r.wb_rd = 5'(wbrd);
        r.stall = 1'(st);
        r.flush = 1'(fl);
        r.exp_issue = 2'(exp_issue);
        rows.push_back(r);
        names.push_back(name);
    endtask

    // wait for clk to reach lvl, each try gives up after 5 ns without an edge
    task automatic wait_clk(input logic lvl);
        int   n;
        logic hit;
        n = 0;
        hit = 1'b0;
        while (!hit && n < 4) begin
            fork
                begin
                    @(clk);
                    hit = (clk === lvl);
                end
                #5;
            join_any
            n++;
        end
        if (!hit) begin
            $display("timeout: no clock edge within the wait limit");
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            $display("** Error %s: expected %h, got %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_icu();
        for (int n = 0; n < 2; n++) begin
            check_val($sformatf("lane%0d_valid_o", n + 1), 32'(e_v[n]), 32'(o_v[n]));
            check_val($sformatf("inst%0d_addr_o", n + 1), e_addr[n], o_addr[n]);
            check_val($sformatf("inst%0d_reg_we_o", n + 1), 32'(e_we[n]), 32'(o_we[n]));
            check_val($sformatf("inst%0d_rd_o", n + 1), 32'(e_rd[n]), 32'(o_rd[n]));
            check_val($sformatf("inst%0d_rs1_o", n + 1), 32'(e_rs1[n]), 32'(o_rs1[n]));
            check_val($sformatf("inst%0d_rs2_o", n + 1), 32'(e_rs2[n]), 32'(o_rs2[n]));
            check_val($sformatf("inst%0d_imm_o", n + 1), e_imm[n], o_imm[n]);
            check_val($sformatf("inst%0d_dec_info_o", n + 1), 32'(e_info[n]), 32'(o_info[n]));
            check_val($sformatf("inst%0d_pred_branch_o", n + 1), 32'(e_pb[n]), 32'(o_pb[n]));
        end
    endtask

    // both lanes of the expected issue register back to zero
    task automatic clear_expected();
        e_v = '{default: '0};
        e_we = '{default: '0};
        e_rd = '{default: '0};
        e_rs1 = '{default: '0};
        e_rs2 = '{default: '0};
        e_addr = '{default: '0};
        e_imm = '{default: '0};
        e_info = '{default: '0};
        e_pb = '{default: '0};
    endtask

    // busy and pair rules, evaluated on the inputs now driven
    function automatic logic lane_busy(input int n);
        return (c_rs1[n] != '0 && pend[c_rs1[n]]) || (c_rs2[n] != '0 && pend[c_rs2[n]])
            || (c_rd[n] != '0 && pend[c_rd[n]]);
    endfunction

    function automatic logic pair_conflict();
        logic dep;
        logic unit;
        dep = c_we[0] && c_rd[0] != '0
            && (c_rd[0] == c_rs1[1] || c_rd[0] == c_rs2[1] || c_rd[0] == c_rd[1]);
        unit = (c_info[0][2:0] == GRP_MEM && c_info[1][2:0] == GRP_MEM)
            || (c_info[0][2:0] == GRP_MUL && c_info[1][2:0] == GRP_MUL);
        return dep || unit;
    endfunction

    task automatic drive_lane(input int n, input lane_t l);
        c_v[n] = l.v;
        c_we[n] = l.we;
        c_rd[n] = l.rd;
        c_rs1[n] = l.rs1;
        c_rs2[n] = l.rs2;
        c_addr[n] = {30'(rand_bits(30)), 2'b00};
        c_imm[n] = rand_bits(32);
        c_info[n] = {13'(rand_bits(13)), l.grp};
        c_pb[n] = 1'(rand_bits(1));
    endtask

    // model state at the rising edge
    task automatic update_model();
        if (flush_i) begin
            pend = '0;
        end else begin
            if (wb_we_i) begin
                pend[wb_rd_i] = 1'b0;
            end
            for (int n = 0; n < 2; n++) begin
                if (grant[n] && c_we[n] && c_rd[n] != '0) begin
                    pend[c_rd[n]] = 1'b1;
                end
            end
        end
        pend[0] = 1'b0;
        if (flush_i) begin
            clear_expected();
        end else if (!stall_dispatch_i) begin
            for (int n = 0; n < 2; n++) begin
                e_v[n] = grant[n];
                if (grant[n]) begin
                    e_we[n] = c_we[n];
                    e_rd[n] = c_rd[n];
                    e_rs1[n] = c_rs1[n];
                    e_rs2[n] = c_rs2[n];
                    e_addr[n] = c_addr[n];
                    e_imm[n] = c_imm[n];
                    e_info[n] = c_info[n];
                    e_pb[n] = c_pb[n];
                end
            end
        end
    endtask

    initial begin
        lane_t idle;
        int    err_before;
        clk = 0;
        reset_i = 1;
        flush_i = 0;
        stall_dispatch_i = 0;
        wb_we_i = 0;
        wb_rd_i = '0;
        lfsr_q = 16'd17407;
        pend = '0;
        errors = 0;
        checks = 0;
        c_v = '{default: '0};
        c_we = '{default: '0};
        c_rd = '{default: '0};
        c_rs1 = '{default: '0};
        c_rs2 = '{default: '0};
        c_addr = '{default: '0};
        c_imm = '{default: '0};
        c_info = '{default: '0};
        c_pb = '{default: '0};
        clear_expected();
        idle = mk_lane(0, 0, 0, 0, 0, GRP_ALU);

        add_row("dual alu", mk_lane(1, 1, 1, 2, 3, GRP_ALU), mk_lane(1, 1, 4, 5, 6, GRP_ALU),
                0, 0, 0, 0, 3);
        add_row("wb x1", idle, idle, 1, 1, 0, 0, 0);
        add_row("wb x4", idle, idle, 1, 4, 0, 0, 0);
        add_row("raw in pair", mk_lane(1, 1, 7, 2, 3, GRP_ALU), mk_lane(1, 1, 8, 7, 0, GRP_ALU),
                0, 0, 0, 0, 1);
        add_row("wb x7", idle, idle, 1, 7, 0, 0, 0);
        add_row("waw in pair", mk_lane(1, 1, 9, 0, 0, GRP_ALU), mk_lane(1, 1, 9, 0, 0, GRP_ALU),
                0, 0, 0, 0, 1);
        add_row("wb x9", idle, idle, 1, 9, 0, 0, 0);
        add_row("two mem", mk_lane(1, 0, 0, 10, 0, GRP_MEM), mk_lane(1, 0, 0, 11, 0, GRP_MEM),
                0, 0, 0, 0, 1);
        add_row("two mul", mk_lane(1, 1, 12, 0, 0, GRP_MUL), mk_lane(1, 1, 13, 0, 0, GRP_MUL),
                0, 0, 0, 0, 1);
        add_row("wb x12", idle, idle, 1, 12, 0, 0, 0);
        add_row("rd x0 pair", mk_lane(1, 1, 0, 0, 0, GRP_ALU), mk_lane(1, 1, 5, 0, 0, GRP_BJP),
                0, 0, 0, 0, 3);
        add_row("wb x5", idle, idle, 1, 5, 0, 0, 0);
        add_row("write x14", mk_lane(1, 1, 14, 0, 0, GRP_ALU), idle, 0, 0, 0, 0, 1);
        add_row("read x14 held", mk_lane(1, 1, 15, 14, 0, GRP_ALU), idle, 0, 0, 0, 0, 0);
        add_row("read x14 wb", mk_lane(1, 1, 15, 14, 0, GRP_ALU), idle, 1, 14, 0, 0, 0);
        add_row("read x14 go", mk_lane(1, 1, 15, 14, 0, GRP_ALU), idle, 0, 0, 0, 0, 1);
        add_row("lane2 busy", mk_lane(1, 1, 16, 0, 0, GRP_ALU), mk_lane(1, 1, 17, 15, 0, GRP_ALU),
                0, 0, 0, 0, 1);
        add_row("wb x15", idle, idle, 1, 15, 0, 0, 0);
        add_row("wb x16", idle, idle, 1, 16, 0, 0, 0);
        add_row("set over wb", mk_lane(1, 1, 18, 0, 0, GRP_ALU), idle, 1, 18, 0, 0, 1);
        add_row("x18 still busy", mk_lane(1, 1, 19, 18, 0, GRP_ALU), idle, 0, 0, 0, 0, 0);
        add_row("pre stall", mk_lane(1, 1, 20, 0, 0, GRP_ALU), mk_lane(1, 1, 21, 0, 0, GRP_MEM),
                0, 0, 0, 0, 3);
        add_row("stall", mk_lane(1, 1, 22, 0, 0, GRP_ALU), idle, 0, 0, 1, 0, 0);
        add_row("flush", mk_lane(1, 1, 22, 0, 0, GRP_ALU), idle, 0, 0, 0, 1, 0);
        add_row("after flush", mk_lane(1, 1, 23, 18, 20, GRP_ALU),
                mk_lane(1, 1, 24, 21, 0, GRP_ALU), 0, 0, 0, 0, 3);

        repeat (10) wait_clk(1'b1);
        wait_clk(1'b0);
        reset_i = 0;
        #2;
        check_val("issue_o", 32'd0, 32'(issue_o));
        check_icu();
        $display("test 0 reset: %s", errors == 0 ? "pass" : "mismatch");
        wait_clk(1'b0);

        foreach (rows[i]) begin
            err_before = errors;
            drive_lane(0, rows[i].l1);
            drive_lane(1, rows[i].l2);
            wb_we_i = rows[i].wb_we;
            wb_rd_i = rows[i].wb_rd;
            stall_dispatch_i = rows[i].stall;
            flush_i = rows[i].flush;
            grant[0] = c_v[0] && !lane_busy(0) && !stall_dispatch_i && !flush_i;
            grant[1] = grant[0] && c_v[1] && !lane_busy(1) && !pair_conflict();
            if (grant != rows[i].exp_issue) begin
                $display("table row %0d and reference model disagree on issue", i + 1);
                errors++;
            end
            #2;
            check_val("issue_o", 32'(grant), 32'(issue_o));
            wait_clk(1'b1);
            update_model();
            #1;
            check_icu();
            $display("test %0d %s: %s", i + 1, names[i],
                     errors == err_before ? "pass" : "mismatch");
            wait_clk(1'b0);
        end

        $display("%0d tests, %0d checks, %0d errors", rows.size() + 1, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
